// ==== ro_cache_pkg.sv ====
// Cache geometry, address and Wishbone port structs, datapath control and status, FSM states
package ro_cache_pkg;

    // ----------------------------------------------------------------------
    // Geometry
    // ----------------------------------------------------------------------
    localparam int num_lines     = 8;
    localparam int associativity = 2;
    localparam int line_width    = 128;
    localparam int adr_width     = 12;
    localparam int index_width   = $clog2(num_lines);
    localparam int tag_width     = adr_width - index_width;
    localparam int way_width     = $clog2(associativity);

    typedef logic [line_width-1:0] line_t;

    // Line address as seen by the cache, tag in the upper bits
    typedef struct packed {
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
    } cache_addr_t;

    // ----------------------------------------------------------------------
    // Wishbone classic, read only
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic [adr_width-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_rsp_t;

    // ----------------------------------------------------------------------
    // Controller and datapath
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [way_width-1:0] way_sel;
        logic                 load;
        logic                 load_lru;
        logic                 dat_x;
    } dp_ctrl_t;

    typedef struct packed {
        logic [associativity-1:0] hit;
        logic [way_width-1:0]     lru;
    } dp_status_t;

    typedef enum logic [2:0] {
        idle,
        check,
        fetch,
        fill,
        respond
    } ctrl_state_t;

endpackage : ro_cache_pkg

// ==== cache_way.sv ====
// One cache way: valid bits, tag and data arrays, tag compare and hit
`timescale 1ns/1ns

module cache_way
    import ro_cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  logic [index_width-1:0] index_in,
    input  logic [tag_width-1:0]   tag_in,
    input  line_t                  data_in,
    output line_t                  data_out,
    output logic                   hit_out
);

    logic [num_lines-1:0] valid_q;
    logic [tag_width-1:0] tag_mem [num_lines];
    line_t                data_mem [num_lines];

    logic                 valid_at_index;
    logic [tag_width-1:0] tag_at_index;

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // Only the valid bits are cleared, so every set starts empty
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (load) begin
            valid_q[index_in] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_mem[index_in]  <= tag_in;
            data_mem[index_in] <= data_in;
        end
    end

    // ----------------------------------------------------------------------
    // Lookup
    // ----------------------------------------------------------------------
    assign valid_at_index = valid_q[index_in];
    assign tag_at_index   = tag_mem[index_in];

    assign hit_out  = valid_at_index && (tag_at_index == tag_in);
    assign data_out = data_mem[index_in];

    // A fill only happens after a miss, so it never rewrites a line that is present
    a_no_refill: assert property (
        @(posedge clk) disable iff (!arst_n)
        load |-> !(valid_at_index && (tag_at_index == tag_in))
    ) else $error("way load targets a line that is already valid with the same tag");

endmodule : cache_way

// ==== cache_lru.sv ====
// Per-set LRU bit, set to the way not used by the most recent access
`timescale 1ns/1ns

module cache_lru
    import ro_cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [way_width-1:0]   mru_in,
    input  logic [index_width-1:0] index_in,
    input  logic                   load_in,
    output logic [way_width-1:0]   lru_out
);

    // One entry per set
    logic [num_lines-1:0][way_width-1:0] lru_q;

    // ----------------------------------------------------------------------
    // Update
    // ----------------------------------------------------------------------

    // With two ways the least recently used one is simply the other way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (load_in) begin
            lru_q[index_in] <= ~mru_in;
        end
    end

    // Read port follows the current index
    assign lru_out = lru_q[index_in];

endmodule : cache_lru

// ==== readonly_cache_datapath.sv ====
// Cache datapath: address split, way load steering, read data mux and memory address
`timescale 1ns/1ns

module readonly_cache_datapath
    import ro_cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  dp_ctrl_t             dp_ctrl,
    input  cache_addr_t          cpu_adr,
    input  line_t                mem_dat,
    output dp_status_t           dp_status,
    output line_t                cpu_dat,
    output logic [adr_width-1:0] mem_adr
);

    logic [tag_width-1:0]     tag;
    logic [index_width-1:0]   index;
    logic [associativity-1:0] way_load;
    logic [associativity-1:0] way_hit;
    line_t                    way_dat [associativity];
    line_t                    sel_dat;
    logic [way_width-1:0]     lru;

    // ----------------------------------------------------------------------
    // Address split
    // ----------------------------------------------------------------------
    assign tag   = cpu_adr.tag;
    assign index = cpu_adr.index;

    // ----------------------------------------------------------------------
    // Ways
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < associativity; w++) begin : g_way
        // Only the selected way sees the load pulse
        assign way_load[w] = dp_ctrl.load && (dp_ctrl.way_sel == w);

        cache_way u_way (
            .clk      (clk),
            .arst_n   (arst_n),
            .load     (way_load[w]),
            .index_in (index),
            .tag_in   (tag),
            .data_in  (mem_dat),
            .data_out (way_dat[w]),
            .hit_out  (way_hit[w])
        );
    end

    cache_lru u_lru (
        .clk      (clk),
        .arst_n   (arst_n),
        .mru_in   (dp_ctrl.way_sel),
        .index_in (index),
        .load_in  (dp_ctrl.load_lru),
        .lru_out  (lru)
    );

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign dp_status.hit = way_hit;
    assign dp_status.lru = lru;

    assign sel_dat = way_dat[dp_ctrl.way_sel];

    // Read data is don't-care outside the ack cycle
    assign cpu_dat = dp_ctrl.dat_x ? 'x : sel_dat;

    // Line requests go to memory unchanged
    assign mem_adr = cpu_adr;

    // Fills always go to one way only, so a tag never sits in both ways of a set
    a_no_dup_line: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(&dp_status.hit)
    ) else $error("same line present in every way of set %0d", index);

endmodule : readonly_cache_datapath

// ==== readonly_cache_control.sv ====
// Cache controller FSM: hit check, line fetch and fill, both Wishbone handshakes
`timescale 1ns/1ns

module readonly_cache_control
    import ro_cache_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cpu_cyc,
    input  logic       cpu_stb,
    output logic       cpu_ack,
    output logic       mem_cyc,
    output logic       mem_stb,
    input  logic       mem_ack,
    input  dp_status_t dp_status,
    output dp_ctrl_t   dp_ctrl
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic                 any_hit;
    logic [way_width-1:0] hit_way;

    // Turn the one-hot hit vector into a way number
    function automatic logic [way_width-1:0] encode_hit(input logic [associativity-1:0] hit);
        logic [way_width-1:0] way;
        way = '0;
        for (int w = 0; w < associativity; w++) begin
            if (hit[w]) begin
                way = w[way_width-1:0];
            end
        end
        return way;
    endfunction

    assign any_hit = |dp_status.hit;
    assign hit_way = encode_hit(dp_status.hit);

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Next state and outputs
    // ----------------------------------------------------------------------
    always_comb begin
        state_d          = state_q;
        cpu_ack          = 1'b0;
        mem_cyc          = 1'b0;
        mem_stb          = 1'b0;
        dp_ctrl.way_sel  = dp_status.lru;
        dp_ctrl.load     = 1'b0;
        dp_ctrl.load_lru = 1'b0;

        case (state_q)
            idle: begin
                if (cpu_cyc && cpu_stb) begin
                    state_d = check;
                end
            end
            check: begin
                if (any_hit) begin
                    // Answer and mark the hit way as most recently used
                    cpu_ack          = 1'b1;
                    dp_ctrl.way_sel  = hit_way;
                    dp_ctrl.load_lru = 1'b1;
                    state_d          = idle;
                end else begin
                    state_d = fetch;
                end
            end
            fetch: begin
                // Held for as long as memory stalls
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                if (mem_ack) begin
                    state_d = fill;
                end
            end
            fill: begin
                // Victim is the LRU way of the set
                dp_ctrl.load = 1'b1;
                state_d      = respond;
            end
            respond: begin
                state_d = check;
            end
            default: begin
                state_d = idle;
            end
        endcase

        dp_ctrl.dat_x = !cpu_ack;
    end

    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpu_ack |-> cpu_stb
    ) else $error("cpu ack given without a strobe");

    a_mem_stb_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_stb && !mem_ack) |=> mem_stb
    ) else $error("mem strobe dropped before ack");

endmodule : readonly_cache_control

// ==== readonly_cache.sv ====
// Read-only line cache top level: controller and datapath between two Wishbone ports
`timescale 1ns/1ns

module readonly_cache
    import ro_cache_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  wb_req_t cpu_req,
    output wb_rsp_t cpu_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    dp_ctrl_t   dp_ctrl;
    dp_status_t dp_status;

    readonly_cache_control u_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_cyc   (cpu_req.cyc),
        .cpu_stb   (cpu_req.stb),
        .cpu_ack   (cpu_rsp.ack),
        .mem_cyc   (mem_req.cyc),
        .mem_stb   (mem_req.stb),
        .mem_ack   (mem_rsp.ack),
        .dp_status (dp_status),
        .dp_ctrl   (dp_ctrl)
    );

    readonly_cache_datapath u_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .dp_ctrl   (dp_ctrl),
        .cpu_adr   (cpu_req.adr),
        .mem_dat   (mem_rsp.dat),
        .dp_status (dp_status),
        .cpu_dat   (cpu_rsp.dat),
        .mem_adr   (mem_req.adr)
    );

endmodule : readonly_cache

// ==== tb_readonly_cache.sv ====
// Read-only cache testbench with clock, reset, memory model, LFSR, checks and directed tests
`timescale 1ns/1ns

module tb_readonly_cache
    import ro_cache_pkg::*;
();

    localparam int          clk_period   = 20;
    localparam logic [15:0] lfsr_seed    = 16'd31659;
    localparam line_t       line_pattern = 128'h5A5A_C3C3_0F0F_9669_A5A5_3C3C_F0F0_6996;

    // About 55 reads of at most 14 cycles each and two resets
    localparam int timeout_cycles = 2000;

    logic    clk;
    logic    arst_n;
    wb_req_t cpu_req;
    wb_rsp_t cpu_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp = '0;

    int fetch_count = 0;
    int ack_count   = 0;
    int cycle_count = 0;

    logic        mem_busy   = 1'b0;
    logic [1:0]  mem_wait   = '0;
    logic [15:0] delay_lfsr = lfsr_seed;

    readonly_cache UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // Memory contents are the address repeated across the line and XORed with a pattern
    function automatic line_t mem_line(input logic [adr_width-1:0] adr);
        logic [11*adr_width-1:0] repeated;
        repeated = {11{adr}};
        return repeated[line_width-1:0] ^ line_pattern;
    endfunction

    function automatic logic [adr_width-1:0] make_addr(input logic [tag_width-1:0] tag,
                                                       input logic [index_width-1:0] index);
        cache_addr_t addr;
        addr.tag   = tag;
        addr.index = index;
        return addr;
    endfunction

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input line_t actual, input line_t expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // Memory model and monitors
    // ----------------------------------------------------------------------

    // Answers a strobe after 0 to 3 cycles using two LFSR bits per request
    always @(posedge clk) begin : memory_model
        logic [1:0] delay;
        if (!arst_n) begin
            mem_rsp.ack <= 1'b0;
            mem_busy    <= 1'b0;
            mem_wait    <= '0;
        end else if (mem_rsp.ack) begin
            mem_rsp.ack <= 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (!mem_busy) begin
                delay_lfsr = lfsr_next(delay_lfsr);
                delay[0]   = delay_lfsr[0];
                delay_lfsr = lfsr_next(delay_lfsr);
                delay[1]   = delay_lfsr[0];
                if (delay == 2'd0) begin
                    mem_rsp.ack <= 1'b1;
                    mem_rsp.dat <= mem_line(mem_req.adr);
                    fetch_count <= fetch_count + 1;
                end else begin
                    mem_busy <= 1'b1;
                    mem_wait <= delay - 2'd1;
                end
            end else if (mem_wait == 2'd0) begin
                mem_rsp.ack <= 1'b1;
                mem_rsp.dat <= mem_line(mem_req.adr);
                fetch_count <= fetch_count + 1;
                mem_busy    <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (cpu_rsp.ack === 1'b1) begin
            ack_count <= ack_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    // ----------------------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_equal(line_t'({cpu_rsp.ack, mem_req.cyc, mem_req.stb}), '0,
                    "ack, mem cyc and mem stb after reset");
    endtask

    // One CPU read checked for data, a single ack and the number of fetches
    task automatic read_expect(input logic [adr_width-1:0] adr, input int exp_fetches,
                               input string what);
        int    fetch_before;
        int    ack_before;
        line_t dat;
        fetch_before = fetch_count;
        ack_before   = ack_count;
        @(posedge clk);
        cpu_req <= '{cyc: 1'b1, stb: 1'b1, adr: adr};
        @(negedge clk);
        while (cpu_rsp.ack !== 1'b1) begin
            @(negedge clk);
        end
        dat = cpu_rsp.dat;
        @(posedge clk);
        cpu_req <= '{cyc: 1'b0, stb: 1'b0, adr: adr};
        // One more cycle so an ack that stays high is also counted
        repeat (2) @(negedge clk);
        check_equal(dat, mem_line(adr), $sformatf("%s, data of line %h", what, adr));
        check_equal(line_t'(ack_count - ack_before), line_t'(1),
                    $sformatf("%s, acks for line %h", what, adr));
        if (exp_fetches >= 0) begin
            check_equal(line_t'(fetch_count - fetch_before), line_t'(exp_fetches),
                        $sformatf("%s, fetches for line %h", what, adr));
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_miss_then_hit();
        read_expect(make_addr(9'h014, 3'd3), 1, "miss then hit");
        read_expect(make_addr(9'h014, 3'd3), 0, "miss then hit");
    endtask

    task automatic test_two_tags_one_set();
        read_expect(make_addr(9'h011, 3'd5), 1, "two tags");
        read_expect(make_addr(9'h1F0, 3'd5), 1, "two tags");
        read_expect(make_addr(9'h011, 3'd5), 0, "two tags");
        read_expect(make_addr(9'h1F0, 3'd5), 0, "two tags");
    endtask

    // After A B A the LRU way holds B, so C replaces it
    task automatic test_lru_replacement();
        read_expect(make_addr(9'h0A1, 3'd6), 1, "lru");
        read_expect(make_addr(9'h0B2, 3'd6), 1, "lru");
        read_expect(make_addr(9'h0A1, 3'd6), 0, "lru");
        read_expect(make_addr(9'h0C3, 3'd6), 1, "lru");
        read_expect(make_addr(9'h0A1, 3'd6), 0, "lru");
        read_expect(make_addr(9'h0B2, 3'd6), 1, "lru");
    endtask

    // Random lines from four small tags, so hits and misses mix
    task automatic test_back_pressure();
        logic [15:0]          addr_lfsr;
        logic [4:0]           bits;
        logic [adr_width-1:0] adr;
        addr_lfsr = lfsr_seed;
        for (int n = 0; n < 24; n++) begin
            for (int b = 0; b < 5; b++) begin
                addr_lfsr = lfsr_next(addr_lfsr);
                bits[b]   = addr_lfsr[0];
            end
            adr = {7'd0, bits};
            read_expect(adr, -1, "back-pressure");
        end
    endtask

    task automatic test_all_sets();
        for (int i = 0; i < num_lines; i++) begin
            read_expect(make_addr(9'h155, i[index_width-1:0]), 1, "all sets fill");
        end
        for (int i = 0; i < num_lines; i++) begin
            read_expect(make_addr(9'h155, i[index_width-1:0]), 0, "all sets reread");
        end
    endtask

    task automatic test_reset_invalidates();
        read_expect(make_addr(9'h155, 3'd2), 0, "before reset");
        apply_reset();
        read_expect(make_addr(9'h155, 3'd2), 1, "after reset");
        read_expect(make_addr(9'h155, 3'd2), 0, "after reset");
    endtask

    initial begin
        arst_n  = 1'b0;
        cpu_req = '0;
        apply_reset();
        test_miss_then_hit();
        test_two_tags_one_set();
        test_lru_replacement();
        test_back_pressure();
        test_all_sets();
        test_reset_invalidates();
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_readonly_cache

// ==== readonly_cache.f ====
ro_cache_pkg.sv
cache_way.sv
cache_lru.sv
readonly_cache_datapath.sv
readonly_cache_control.sv
readonly_cache.sv
tb_readonly_cache.sv

// ==== Makefile ====
# Verilator build and run for the read-only cache testbench

VERILATOR ?= verilator
TOP       ?= tb_readonly_cache
FILELIST  ?= readonly_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := Done: no errors
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
